//--- rtl/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath and storage sizes
`define XLEN       32
`define NUM_REGS   32
`define REG_IDX_W  5
`define DMEM_WORDS 64
`define DMEM_IDX_W 6

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// major opcodes and the funct3 codes this backend understands
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011

`define F3_ADD_SUB 3'b000
`define F3_SLT     3'b010
`define F3_XOR     3'b100
`define F3_OR      3'b110
`define F3_AND     3'b111
`define F3_WORD    3'b010

`endif

//--- rtl/core_pkg.sv
`include "core_consts.svh"

package core_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction word views, all sharing the opcode in the low 7 bits
    typedef struct packed {
        logic [6:0]            funct7;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [`REG_IDX_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [`REG_IDX_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [`REG_IDX_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic                  is_mem;
        logic                  is_store;
        alu_op_e               alu_op;
        logic [`REG_IDX_W-1:0] rd;
        logic                  need_to_wb;
        logic [`XLEN-1:0]      src1;
        // register operand or sign-extended immediate
        logic [`XLEN-1:0]      src2;
        logic [`XLEN-1:0]      store_data;
    } uop_t;

    typedef struct packed {
        logic                  valid;
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      data;
    } wb_req_t;

endpackage

//--- rtl/uop_pipereg.sv
module uop_pipereg #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     flush_valid,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_payload,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_payload
);
    logic in_fire;
    logic out_fire;

    // an empty stage takes input even when the consumer is stalled
    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            out_valid   <= 1'b0;
            out_payload <= '0;
        end else if (flush_valid) begin
            out_valid   <= 1'b0;
            out_payload <= '0;
        end else if (in_fire) begin
            out_valid   <= 1'b1;
            out_payload <= in_payload;
        end else if (out_fire) begin
            // payload simply holds once drained
            out_valid <= 1'b0;
        end
    end

    a_stall_stable: assert property (@(posedge clock) disable iff (!reset_n)
        out_valid && !out_ready && !flush_valid |=> out_valid && $stable(out_payload));

endmodule

//--- rtl/regfile.sv
`include "core_consts.svh"

module regfile (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic [`REG_IDX_W-1:0] rs1_idx,
    input  logic [`REG_IDX_W-1:0] rs2_idx,
    output logic [`XLEN-1:0]      rs1_data,
    output logic [`XLEN-1:0]      rs2_data,
    input  core_pkg::wb_req_t     wb
);
    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // x0 reads as zero whatever the array holds
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

//--- rtl/uop_decoder.sv
`include "core_consts.svh"

module uop_decoder (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  flush_valid,
    input  logic                  instr_valid,
    input  core_pkg::instr_u      instr,
    output logic                  instr_ready,
    output logic [`REG_IDX_W-1:0] rs1_idx,
    output logic [`REG_IDX_W-1:0] rs2_idx,
    input  logic [`XLEN-1:0]      rs1_data,
    input  logic [`XLEN-1:0]      rs2_data,
    output core_pkg::uop_t        uop,
    output logic                  uop_valid,
    input  logic                  uop_ready,
    input  core_pkg::wb_req_t     wb
);
    import core_pkg::*;

    logic [`NUM_REGS-1:0]  busy;
    logic [6:0]            opcode;
    logic                  supported;
    logic                  reads_rs2;
    logic                  writes_rd;
    logic [`REG_IDX_W-1:0] rd_idx;
    logic [11:0]           imm12;
    logic                  rs1_busy;
    logic                  rs2_busy;
    logic                  rd_busy;
    logic                  hazard;
    logic                  accept;

    assign opcode  = instr.r_fmt.opcode;
    assign rs1_idx = instr.i_fmt.rs1;

    always_comb begin
        supported = 1'b0;
        reads_rs2 = 1'b0;
        writes_rd = 1'b0;
        rd_idx    = instr.i_fmt.rd;
        rs2_idx   = instr.r_fmt.rs2;
        imm12     = instr.i_fmt.imm12;
        uop       = '0;
        case (opcode)
            `OPC_OP: begin
                supported = 1'b1;
                reads_rs2 = 1'b1;
                writes_rd = 1'b1;
                rd_idx    = instr.r_fmt.rd;
                case (instr.r_fmt.funct3)
                    `F3_ADD_SUB: uop.alu_op = instr.r_fmt.funct7[5] ? ALU_SUB : ALU_ADD;
                    `F3_SLT:     uop.alu_op = ALU_SLT;
                    `F3_XOR:     uop.alu_op = ALU_XOR;
                    `F3_OR:      uop.alu_op = ALU_OR;
                    `F3_AND:     uop.alu_op = ALU_AND;
                    default:     supported = 1'b0;
                endcase
            end
            `OPC_OP_IMM: begin
                supported = 1'b1;
                writes_rd = 1'b1;
                case (instr.i_fmt.funct3)
                    `F3_ADD_SUB: uop.alu_op = ALU_ADD;
                    `F3_XOR:     uop.alu_op = ALU_XOR;
                    `F3_OR:      uop.alu_op = ALU_OR;
                    `F3_AND:     uop.alu_op = ALU_AND;
                    default:     supported = 1'b0;
                endcase
            end
            `OPC_LOAD: begin
                supported  = (instr.i_fmt.funct3 == `F3_WORD);
                writes_rd  = 1'b1;
                uop.is_mem = 1'b1;
            end
            `OPC_STORE: begin
                supported    = (instr.s_fmt.funct3 == `F3_WORD);
                reads_rs2    = 1'b1;
                rs2_idx      = instr.s_fmt.rs2;
                imm12        = {instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
                uop.is_mem   = 1'b1;
                uop.is_store = 1'b1;
            end
            default: ;
        endcase
        uop.rd         = rd_idx;
        uop.need_to_wb = writes_rd && (rd_idx != '0);
        uop.src1       = rs1_data;
        uop.src2       = (opcode == `OPC_OP) ? rs2_data : {{(`XLEN-12){imm12[11]}}, imm12};
        uop.store_data = rs2_data;
    end

    // x0 never gets a busy bit
    assign rs1_busy = supported && busy[rs1_idx];
    assign rs2_busy = supported && reads_rs2 && busy[rs2_idx];
    assign rd_busy  = supported && writes_rd && busy[rd_idx];
    assign hazard   = rs1_busy || rs2_busy || rd_busy;

    assign instr_ready = uop_ready && !hazard && !flush_valid;
    // writes to x0 and unknown words are taken off the input and go nowhere
    assign uop_valid   = instr_valid && supported && (uop.need_to_wb || uop.is_store)
                         && !hazard && !flush_valid;
    assign accept      = uop_valid && uop_ready;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy <= '0;
        end else if (flush_valid) begin
            busy <= '0;
        end else begin
            if (wb.valid) begin
                busy[wb.rd] <= 1'b0;
            end
            if (accept && uop.need_to_wb) begin
                busy[uop.rd] <= 1'b1;
            end
        end
    end

    // a source that is still owed a write-back is never issued
    a_no_busy_src: assert property (@(posedge clock) disable iff (!reset_n)
        uop_valid |-> !(wb.valid && ((wb.rd == rs1_idx)
                                     || (reads_rs2 && (wb.rd == rs2_idx)))));

endmodule

//--- rtl/alu_lane.sv
`include "core_consts.svh"

module alu_lane (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              flush_valid,
    input  core_pkg::uop_t    uop,
    input  logic              uop_valid,
    output logic              uop_ready,
    output core_pkg::wb_req_t wb_req,
    input  logic              grant
);
    import core_pkg::*;

    logic [`XLEN-1:0] result;
    wb_req_t          res_req;
    wb_req_t          held_req;
    logic             held_valid;

    always_comb begin
        case (uop.alu_op)
            ALU_SUB: result = uop.src1 - uop.src2;
            ALU_AND: result = uop.src1 & uop.src2;
            ALU_OR:  result = uop.src1 | uop.src2;
            ALU_XOR: result = uop.src1 ^ uop.src2;
            ALU_SLT: result = {{(`XLEN-1){1'b0}}, ($signed(uop.src1) < $signed(uop.src2))};
            default: result = uop.src1 + uop.src2;
        endcase
    end

    always_comb begin
        res_req.valid = 1'b1;
        res_req.rd    = uop.rd;
        res_req.data  = result;
    end

    uop_pipereg #(.payload_t(wb_req_t)) wb_pipereg (
        .clock      (clock),
        .reset_n    (reset_n),
        .flush_valid(flush_valid),
        .in_valid   (uop_valid),
        .in_ready   (uop_ready),
        .in_payload (res_req),
        .out_valid  (held_valid),
        .out_ready  (grant),
        .out_payload(held_req)
    );

    always_comb begin
        wb_req       = held_req;
        wb_req.valid = held_valid;
    end

endmodule

//--- rtl/mem_lane.sv
`include "core_consts.svh"

module mem_lane (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              flush_valid,
    input  core_pkg::uop_t    uop,
    input  logic              uop_valid,
    output logic              uop_ready,
    output core_pkg::wb_req_t wb_req,
    input  logic              grant
);
    import core_pkg::*;

    logic [`XLEN-1:0]       dmem [`DMEM_WORDS];
    logic [`XLEN-1:0]       addr;
    logic [`DMEM_IDX_W-1:0] word_idx;
    logic                   ld_in_ready;
    logic                   store_fire;
    wb_req_t                ld_req;
    wb_req_t                held_req;
    logic                   held_valid;

    assign addr     = uop.src1 + uop.src2;
    assign word_idx = addr[`DMEM_IDX_W+1:2];

    // stores complete on acceptance, only loads need the result register
    assign uop_ready  = !uop.need_to_wb || ld_in_ready;
    assign store_fire = uop_valid && uop_ready && uop.is_store;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (store_fire) begin
            dmem[word_idx] <= uop.store_data;
        end
    end

    always_comb begin
        ld_req.valid = 1'b1;
        ld_req.rd    = uop.rd;
        ld_req.data  = dmem[word_idx];
    end

    uop_pipereg #(.payload_t(wb_req_t)) wb_pipereg (
        .clock      (clock),
        .reset_n    (reset_n),
        .flush_valid(flush_valid),
        .in_valid   (uop_valid && uop.need_to_wb),
        .in_ready   (ld_in_ready),
        .in_payload (ld_req),
        .out_valid  (held_valid),
        .out_ready  (grant),
        .out_payload(held_req)
    );

    always_comb begin
        wb_req       = held_req;
        wb_req.valid = held_valid;
    end

endmodule

//--- rtl/wb_arbiter.sv
module wb_arbiter (
    input  logic              clock,
    input  logic              reset_n,
    input  core_pkg::wb_req_t alu_req,
    input  core_pkg::wb_req_t mem_req,
    output logic              alu_grant,
    output logic              mem_grant,
    output core_pkg::wb_req_t wb
);
    // low favours the ALU lane, high favours the memory lane
    logic prio;

    assign alu_grant = alu_req.valid && (!mem_req.valid || !prio);
    assign mem_grant = mem_req.valid && (!alu_req.valid || prio);

    always_comb begin
        wb = '0;
        if (alu_grant) begin
            wb = alu_req;
        end else if (mem_grant) begin
            wb = mem_req;
        end
    end

    // flipping on every grant hands a losing lane the next slot
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            prio <= 1'b0;
        end else if (alu_grant || mem_grant) begin
            prio <= !prio;
        end
    end

    a_grant_onehot: assert property (@(posedge clock) disable iff (!reset_n)
        !(alu_grant && mem_grant));

    // a request that loses is served on the next cycle if it still waits
    a_alu_no_starve: assert property (@(posedge clock) disable iff (!reset_n)
        alu_req.valid && mem_grant |=> alu_grant || !alu_req.valid);

    a_mem_no_starve: assert property (@(posedge clock) disable iff (!reset_n)
        mem_req.valid && alu_grant |=> mem_grant || !mem_req.valid);

endmodule

//--- rtl/exec_backend_top.sv
`include "core_consts.svh"

module exec_backend_top (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              flush_valid,
    input  logic              instr_valid,
    input  core_pkg::instr_u  instr,
    output logic              instr_ready,
    output core_pkg::wb_req_t wb
);
    import core_pkg::*;

    logic [`REG_IDX_W-1:0] rs1_idx;
    logic [`REG_IDX_W-1:0] rs2_idx;
    logic [`XLEN-1:0]      rs1_data;
    logic [`XLEN-1:0]      rs2_data;
    uop_t                  dec_uop;
    logic                  dec_valid;
    logic                  dec_ready;
    uop_t                  s1_uop;
    logic                  s1_valid;
    logic                  s1_ready;
    logic                  alu_ready;
    logic                  mem_ready;
    wb_req_t               alu_req;
    wb_req_t               mem_req;
    logic                  alu_grant;
    logic                  mem_grant;

    uop_decoder decoder (
        .clock(clock), .reset_n(reset_n), .flush_valid(flush_valid),
        .instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .uop(dec_uop), .uop_valid(dec_valid), .uop_ready(dec_ready), .wb(wb)
    );

    regfile rf (
        .clock(clock), .reset_n(reset_n),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wb(wb)
    );

    uop_pipereg #(.payload_t(uop_t)) s1_pipereg (
        .clock(clock), .reset_n(reset_n), .flush_valid(flush_valid),
        .in_valid(dec_valid), .in_ready(dec_ready), .in_payload(dec_uop),
        .out_valid(s1_valid), .out_ready(s1_ready), .out_payload(s1_uop)
    );

    // the held micro-op goes to one lane only, chosen by is_mem
    assign s1_ready = s1_uop.is_mem ? mem_ready : alu_ready;

    alu_lane alu (
        .clock(clock), .reset_n(reset_n), .flush_valid(flush_valid),
        .uop(s1_uop), .uop_valid(s1_valid && !s1_uop.is_mem), .uop_ready(alu_ready),
        .wb_req(alu_req), .grant(alu_grant)
    );

    mem_lane lsu (
        .clock(clock), .reset_n(reset_n), .flush_valid(flush_valid),
        .uop(s1_uop), .uop_valid(s1_valid && s1_uop.is_mem), .uop_ready(mem_ready),
        .wb_req(mem_req), .grant(mem_grant)
    );

    wb_arbiter arb (
        .clock(clock), .reset_n(reset_n),
        .alu_req(alu_req), .mem_req(mem_req),
        .alu_grant(alu_grant), .mem_grant(mem_grant), .wb(wb)
    );

endmodule

//--- tb/tb_backend.sv
`include "core_consts.svh"

module tb_backend;
    import core_pkg::*;

    localparam int CLOCK_PERIOD = 100;
    localparam int N_ALU = 200;
    localparam int N_MEM = 100;
    localparam int N_MIX = 200;
    localparam int N_ODD = 60;
    localparam int N_FLUSH = 6;
    // a state reload is 7 register writes and 16 stores
    localparam int N_RELOAD = 23;
    localparam int TOTAL_INSTR = 2 * N_RELOAD + 2 * N_ALU + N_MEM + N_MIX + N_ODD + N_FLUSH;
    localparam int WATCHDOG_CYCLES = 20 * TOTAL_INSTR + 200;

    typedef struct packed {
        logic                  writes;
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      value;
    } ref_result_t;

    logic             clock;
    logic             reset_n;
    logic             flush_valid;
    logic             instr_valid;
    instr_u           instr;
    logic             instr_ready;
    wb_req_t          wb;

    logic [15:0]      lfsr;
    logic [`XLEN-1:0] model_regs [`NUM_REGS];
    logic [`XLEN-1:0] model_mem [`DMEM_WORDS];
    logic [`XLEN-1:0] expect_data [`NUM_REGS];
    logic             pending [`NUM_REGS];
    int               exp_count;
    int               wb_count;
    int               error_count;
    string            test_name;

    exec_backend_top dut0 (
        .clock      (clock),
        .reset_n    (reset_n),
        .flush_valid(flush_valid),
        .instr_valid(instr_valid),
        .instr      (instr),
        .instr_ready(instr_ready),
        .wb         (wb)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus generation

    // taps 16, 14, 13 and 11, one step per bit taken
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // only x0..x7 are used so that hazards come up often
    function automatic logic [4:0] pick_reg();
        return {2'b00, 3'(next_bits(3))};
    endfunction

    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type_word(input logic [11:0] imm, input logic [4:0] rs2,
                                                input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, `F3_WORD, imm[4:0], `OPC_STORE};
    endfunction

    function automatic logic [31:0] alu_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [2:0]  sel;
        logic        r_form;
        logic [31:0] word;
        rd     = pick_reg();
        rs1    = pick_reg();
        rs2    = pick_reg();
        imm    = 12'(next_bits(12));
        sel    = 3'(next_bits(3));
        r_form = 1'(next_bits(1));
        if (r_form) begin
            case (sel)
                3'd0:    word = r_type_word(7'h00, rs2, rs1, `F3_ADD_SUB, rd);
                3'd1:    word = r_type_word(7'h20, rs2, rs1, `F3_ADD_SUB, rd);
                3'd2:    word = r_type_word(7'h00, rs2, rs1, `F3_AND, rd);
                3'd3:    word = r_type_word(7'h00, rs2, rs1, `F3_OR, rd);
                3'd4:    word = r_type_word(7'h00, rs2, rs1, `F3_XOR, rd);
                default: word = r_type_word(7'h00, rs2, rs1, `F3_SLT, rd);
            endcase
        end else begin
            case (sel[1:0])
                2'd0:    word = i_type_word(imm, rs1, `F3_ADD_SUB, rd, `OPC_OP_IMM);
                2'd1:    word = i_type_word(imm, rs1, `F3_XOR, rd, `OPC_OP_IMM);
                2'd2:    word = i_type_word(imm, rs1, `F3_OR, rd, `OPC_OP_IMM);
                default: word = i_type_word(imm, rs1, `F3_AND, rd, `OPC_OP_IMM);
            endcase
        end
        return word;
    endfunction

    // word addresses 0..15, always based on x0
    function automatic logic [31:0] mem_instr();
        logic [4:0]  reg_sel;
        logic [11:0] offset;
        logic        is_load;
        reg_sel = pick_reg();
        offset  = {6'd0, 4'(next_bits(4)), 2'b00};
        is_load = 1'(next_bits(1));
        if (is_load) begin
            return i_type_word(offset, 5'd0, `F3_WORD, reg_sel, `OPC_LOAD);
        end
        return s_type_word(offset, reg_sel, 5'd0);
    endfunction

    function automatic logic [31:0] mixed_instr();
        if (1'(next_bits(1))) begin
            return alu_instr();
        end
        return mem_instr();
    endfunction

    // x0 destinations, unknown opcodes and reads of x0
    function automatic logic [31:0] odd_instr();
        logic [1:0]  sel;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [31:0] word;
        sel = 2'(next_bits(2));
        ra  = pick_reg();
        rb  = pick_reg();
        case (sel)
            2'd0:    word = r_type_word(7'h00, ra, rb, `F3_ADD_SUB, 5'd0);
            2'd1:    word = {25'(next_bits(25)), 7'b1101111};
            2'd2:    word = {25'(next_bits(25)), 7'b0110111};
            default: word = r_type_word(7'h00, ra, 5'd0, `F3_OR, rb);
        endcase
        return word;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model, executed in program order at acceptance
    function automatic ref_result_t run_reference(input logic [31:0] w);
        ref_result_t r;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] addr;
        r     = '0;
        rd    = w[11:7];
        f3    = w[14:12];
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        case (w[6:0])
            `OPC_OP: begin
                r.writes = 1'b1;
                case (f3)
                    `F3_ADD_SUB: r.value = w[30] ? a - b : a + b;
                    `F3_SLT:     r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `F3_XOR:     r.value = a ^ b;
                    `F3_OR:      r.value = a | b;
                    `F3_AND:     r.value = a & b;
                    default:     r.writes = 1'b0;
                endcase
            end
            `OPC_OP_IMM: begin
                r.writes = 1'b1;
                case (f3)
                    `F3_ADD_SUB: r.value = a + imm_i;
                    `F3_XOR:     r.value = a ^ imm_i;
                    `F3_OR:      r.value = a | imm_i;
                    `F3_AND:     r.value = a & imm_i;
                    default:     r.writes = 1'b0;
                endcase
            end
            `OPC_LOAD: begin
                if (f3 == `F3_WORD) begin
                    addr     = a + imm_i;
                    r.writes = 1'b1;
                    r.value  = model_mem[addr[7:2]];
                end
            end
            `OPC_STORE: begin
                if (f3 == `F3_WORD) begin
                    addr                  = a + imm_s;
                    model_mem[addr[7:2]] = b;
                end
            end
            default: ;
        endcase
        if (rd == 5'd0) begin
            r.writes = 1'b0;
        end
        r.rd = rd;
        if (r.writes) begin
            model_regs[rd] = r.value;
        end
        return r;
    endfunction

    // called on a rising edge, returns on the edge where the word was taken
    task automatic issue_instr(input logic [31:0] w);
        ref_result_t r;
        instr       <= w;
        instr_valid <= 1'b1;
        @(posedge clock);
        while (!instr_ready) @(posedge clock);
        r = run_reference(w);
        if (r.writes) begin
            expect_data[r.rd] = r.value;
            pending[r.rd]     = 1'b1;
            exp_count++;
        end
    endtask

    task automatic drain_pipeline();
        instr_valid <= 1'b0;
        @(negedge clock);
        while (wb_count != exp_count) @(negedge clock);
        repeat (4) @(negedge clock);
        compare_values($sformatf("%s wb count", test_name), exp_count, wb_count);
        @(posedge clock);
    endtask

    task automatic reload_state();
        logic [11:0] imm;
        for (int i = 1; i < 8; i++) begin
            imm = 12'(next_bits(12));
            issue_instr(i_type_word(imm, 5'd0, `F3_ADD_SUB, 5'(i), `OPC_OP_IMM));
        end
        for (int w = 0; w < 16; w++) begin
            issue_instr(s_type_word(12'(w * 4), pick_reg(), 5'd0));
        end
    endtask

    task automatic flush_in_flight();
        repeat (N_FLUSH) issue_instr(mixed_instr());
        instr_valid <= 1'b0;
        flush_valid <= 1'b1;
        @(posedge clock);
        flush_valid <= 1'b0;
        @(posedge clock);
        compare_values($sformatf("%s wb after flush", test_name), 32'd0, {31'd0, wb.valid});
        compare_values($sformatf("%s ready after flush", test_name), 32'd1,
                       {31'd0, instr_ready});
        // whatever was flushed will never write back
        for (int r = 0; r < `NUM_REGS; r++) begin
            pending[r] = 1'b0;
        end
        exp_count = wb_count;
    endtask

    always @(posedge clock) begin
        if (wb.valid) begin
            compare_values($sformatf("%s wb to idle rd %0d", test_name, wb.rd), 32'd1,
                           {31'd0, pending[wb.rd]});
            compare_values($sformatf("%s wb data rd %0d", test_name, wb.rd),
                           expect_data[wb.rd], wb.data);
            pending[wb.rd] = 1'b0;
            wb_count++;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

    initial begin
        reset_n     = 1'b0;
        flush_valid = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr        = 16'd59476;
        exp_count   = 0;
        wb_count    = 0;
        error_count = 0;
        test_name   = "reset";
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i]  = '0;
            expect_data[i] = '0;
            pending[i]     = 1'b0;
        end
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (3) @(posedge clock);
        reset_n <= 1'b1;
        repeat (5) begin
            @(posedge clock);
            compare_values("reset instr_ready", 32'd1, {31'd0, instr_ready});
            compare_values("reset wb valid", 32'd0, {31'd0, wb.valid});
        end

        test_name = "reload";
        reload_state();
        drain_pipeline();
        test_name = "alu";
        repeat (N_ALU) issue_instr(alu_instr());
        drain_pipeline();
        test_name = "store_load";
        repeat (N_MEM) issue_instr(mem_instr());
        drain_pipeline();
        test_name = "contention";
        repeat (N_MIX) issue_instr(mixed_instr());
        drain_pipeline();
        test_name = "x0_unsupported";
        repeat (N_ODD) issue_instr(odd_instr());
        drain_pipeline();

        test_name = "flush";
        flush_in_flight();
        reload_state();
        drain_pipeline();
        test_name = "alu_after_flush";
        repeat (N_ALU) issue_instr(alu_instr());
        drain_pipeline();

        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

endmodule

//--- src.f
+incdir+rtl
rtl/core_pkg.sv
rtl/uop_pipereg.sv
rtl/regfile.sv
rtl/uop_decoder.sv
rtl/alu_lane.sv
rtl/mem_lane.sv
rtl/wb_arbiter.sv
rtl/exec_backend_top.sv
tb/tb_backend.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_backend \
    -o sim_backend &&
./obj_dir/sim_backend | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
echo "simulation run succeeded" ||
{ echo "simulation run failed"; exit 1; }
